/* all.f */
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_alu.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_data_port.sv
verilog/rv_control.sv
verilog/rv_core_top.sv
verification/rv_mem_model.sv
verification/rv_core_tb.sv

/* include/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// Fetch address after anrst or nrst
`define RV_RESET_PC 32'h0000_0000

`endif

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int period_ns        = 4;
  localparam int total_instr      = 35;
  localparam int cycles_per_instr = 20;

  logic     clk;
  logic     anrst;
  logic     nrst;
  logic     inst_req;
  xlen_t    inst_addr;
  logic     inst_gnt;
  logic     inst_rvalid;
  xlen_t    inst_rdata;
  logic     data_req;
  mem_req_t data_out;
  logic     data_gnt;
  logic     data_rvalid;
  xlen_t    data_rdata;
  logic     retire_valid;
  retire_t  retire;

  xlen_t   prog [0:63];
  retire_t exp_q[$];
  retire_t retire_q[$];
  int      error_count;
  int      check_count;

  rv_core_top u_rv_core_top (
    .clk          (clk),
    .anrst        (anrst),
    .nrst         (nrst),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .inst_gnt     (inst_gnt),
    .inst_rvalid  (inst_rvalid),
    .inst_rdata   (inst_rdata),
    .data_req     (data_req),
    .data_out     (data_out),
    .data_gnt     (data_gnt),
    .data_rvalid  (data_rvalid),
    .data_rdata   (data_rdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  rv_mem_model u_imem (
    .clk    (clk),
    .anrst  (anrst),
    .nrst   (nrst),
    .req    (inst_req),
    .addr   (inst_addr),
    .wdata  (32'h0),
    .strb   ('0),
    .we     (1'b0), // Read-only
    .gnt    (inst_gnt),
    .rvalid (inst_rvalid),
    .rdata  (inst_rdata)
  );

  rv_mem_model u_dmem (
    .clk    (clk),
    .anrst  (anrst),
    .nrst   (nrst),
    .req    (data_req),
    .addr   (data_out.addr),
    .wdata  (data_out.wdata),
    .strb   (data_out.strb),
    .we     (data_out.we),
    .gnt    (data_gnt),
    .rvalid (data_rvalid),
    .rdata  (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (retire_valid) begin
      retire_q.push_back(retire);
    end
  end

  // Instruction formats
  function automatic xlen_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic xlen_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input funct3_t f3, input reg_addr_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
  endfunction

  function automatic xlen_t u_type(input logic [19:0] imm, input reg_addr_t rd, input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic xlen_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  // Places a word and queues the retire it should produce
  task automatic add_instr(input xlen_t pc, input xlen_t word, input reg_addr_t rd,
                           input xlen_t wdata);
    retire_t r;
    prog[pc[7:2]] = word;
    r.pc    = pc;
    r.rd    = rd;
    r.wdata = wdata;
    r.we    = (rd != '0);
    exp_q.push_back(r);
  endtask

  task automatic pulse_nrst();
    @(negedge clk);
    nrst <= 1'b0;
    @(negedge clk);
    nrst <= 1'b1;
    retire_q.delete();
  endtask

  task automatic start_program();
    for (int i = 0; i < 64; i++) begin
      u_imem.mem[i] = prog[i];
      prog[i]       = '0;
    end
    pulse_nrst();
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    check_count++;
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  // Data and index only matter when the write flag is set
  task automatic check_retire(input string name, input retire_t exp, input retire_t act);
    logic ok;
    ok = (act.pc === exp.pc) && (act.we === exp.we);
    if (exp.we) begin
      ok = ok && (act.rd === exp.rd) && (act.wdata === exp.wdata);
    end
    check_count++;
    if (!ok) begin
      $display("Fail %s: expected pc %h rd %0d data %h we %b, actual pc %h rd %0d data %h we %b",
               name, exp.pc, exp.rd, exp.wdata, exp.we, act.pc, act.rd, act.wdata, act.we);
      error_count++;
    end
  endtask

  task automatic check_program(input string name);
    int n;
    int cycles;
    n      = exp_q.size();
    cycles = 0;
    while ((retire_q.size() < n) && (cycles < n * cycles_per_instr)) begin
      @(negedge clk);
      cycles++;
    end
    if (retire_q.size() < n) begin
      $display("Error in %s: only %0d of %0d instructions retired", name, retire_q.size(), n);
      error_count++;
    end
    foreach (exp_q[i]) begin
      if (i < retire_q.size()) begin
        check_retire(name, exp_q[i], retire_q[i]);
      end
    end
    exp_q.delete();
  endtask

  task automatic alu_ops();
    add_instr(0, i_type(12'd100, 0, 3'b000, 1, OP_IMM), 1, 32'd100);
    add_instr(4, i_type(12'hFF9, 0, 3'b000, 2, OP_IMM), 2, 32'hFFFF_FFF9); // -7
    add_instr(8, r_type(7'h00, 2, 1, 3'b000, 3), 3, 32'h0000_005D);
    add_instr(12, r_type(7'h20, 2, 1, 3'b000, 4), 4, 32'h0000_006B);
    add_instr(16, r_type(7'h00, 1, 2, 3'b010, 5), 5, 32'd1);
    add_instr(20, r_type(7'h00, 1, 2, 3'b011, 6), 6, 32'd0);
    add_instr(24, r_type(7'h00, 2, 1, 3'b100, 7), 7, 32'hFFFF_FF9D);
    add_instr(28, r_type(7'h00, 2, 1, 3'b110, 8), 8, 32'hFFFF_FFFD);
    add_instr(32, r_type(7'h00, 2, 1, 3'b111, 9), 9, 32'h0000_0060);
    add_instr(36, i_type(12'd4, 0, 3'b000, 10, OP_IMM), 10, 32'd4);
    add_instr(40, r_type(7'h00, 10, 1, 3'b001, 11), 11, 32'h0000_0640);
    add_instr(44, r_type(7'h00, 10, 2, 3'b101, 12), 12, 32'h0FFF_FFFF);
    add_instr(48, r_type(7'h20, 10, 2, 3'b101, 13), 13, 32'hFFFF_FFFF);
    add_instr(52, i_type(12'h401, 2, 3'b101, 14, OP_IMM), 14, 32'hFFFF_FFFC); // SRAI by 1
    start_program();
    check_program("alu_ops");
  endtask

  task automatic upper_imm();
    add_instr(0, u_type(20'h12345, 1, LUI), 1, 32'h1234_5000);
    add_instr(4, u_type(20'h00010, 2, AUIPC), 2, 32'h0001_0004);
    start_program();
    check_program("upper_imm");
  endtask

  task automatic store_load();
    add_instr(0, i_type(12'h100, 0, 3'b000, 1, OP_IMM), 1, 32'h0000_0100);
    add_instr(4, u_type(20'hCAFEB, 2, LUI), 2, 32'hCAFE_B000);
    add_instr(8, i_type(12'h0EE, 2, 3'b000, 2, OP_IMM), 2, 32'hCAFE_B0EE);
    add_instr(12, s_type(12'd8, 2, 1), 0, 32'h0);
    add_instr(16, i_type(12'd8, 1, 3'b010, 3, LOAD), 3, 32'hCAFE_B0EE);
    add_instr(20, s_type(12'hFFC, 3, 1), 0, 32'h0); // Negative offset
    add_instr(24, i_type(12'hFFC, 1, 3'b010, 4, LOAD), 4, 32'hCAFE_B0EE);
    start_program();
    check_program("store_load");
    check_word("store_load", 32'hCAFE_B0EE, u_dmem.mem[32'h108 >> 2]);
    check_word("store_load", 32'hCAFE_B0EE, u_dmem.mem[32'h0FC >> 2]);
  endtask

  task automatic jumps();
    add_instr(0, j_type(21'd12, 1), 1, 32'd4);
    add_instr(12, i_type(12'h020, 0, 3'b000, 2, OP_IMM), 2, 32'h0000_0020);
    add_instr(16, i_type(12'd1, 2, 3'b000, 3, JALR), 3, 32'd20); // Target 0x21 with bit 0 dropped
    add_instr(32, i_type(12'd7, 0, 3'b000, 4, OP_IMM), 4, 32'd7);
    start_program();
    check_program("jumps");
  endtask

  task automatic zero_reg();
    add_instr(0, i_type(12'd5, 0, 3'b000, 0, OP_IMM), 0, 32'd5);
    add_instr(4, i_type(12'd9, 0, 3'b000, 1, OP_IMM), 1, 32'd9);
    add_instr(8, r_type(7'h00, 1, 0, 3'b000, 2), 2, 32'd9);
    start_program();
    check_program("zero_reg");
  endtask

  task automatic sync_reset();
    xlen_t copy_x1;
    copy_x1 = i_type(12'd0, 1, 3'b000, 5, OP_IMM); // x5 = x1
    add_instr(0, copy_x1, 5, 32'd0);
    add_instr(4, i_type(12'd55, 0, 3'b000, 1, OP_IMM), 1, 32'd55);
    add_instr(8, j_type(21'h1F_FFF8, 0), 0, 32'd12); // Back to 0
    add_instr(0, copy_x1, 5, 32'd55);
    start_program();
    check_program("sync_reset");
    add_instr(`RV_RESET_PC, copy_x1, 5, 32'd0);
    pulse_nrst();
    check_program("sync_reset");
  endtask

  initial begin
    #((total_instr * cycles_per_instr + 100) * period_ns);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    error_count = 0;
    check_count = 0;
    anrst       = 1'b0;
    nrst        = 1'b1;
    for (int i = 0; i < 64; i++) begin
      prog[i] = '0;
    end
    repeat (8) @(negedge clk);
    anrst <= 1'b1;
    alu_ops();
    upper_imm();
    store_load();
    jumps();
    zero_reg();
    sync_reset();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/rv_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_model
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  anrst,
  input  logic  nrst,
  input  logic  req,
  input  xlen_t addr,
  input  xlen_t wdata,
  input  strb_t strb,
  input  logic  we,
  output logic  gnt,
  output logic  rvalid,
  output xlen_t rdata
);

  xlen_t  mem [0:255];
  integer seed;
  integer delay;
  logic   write_l;
  xlen_t  addr_l;
  xlen_t  wdata_l;
  strb_t  strb_l;

  initial begin
    seed   = 75;
    delay  = -1;
    gnt    = 1'b0;
    rvalid = 1'b0;
    rdata  = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
  end

  // Outputs change on the falling edge for the core to sample on the rising edge
  always @(negedge clk) begin
    rvalid <= 1'b0;
    if (!anrst || !nrst) begin
      gnt   <= 1'b0;
      delay = -1;
    end else if (gnt) begin
      gnt <= 1'b0; // Grant taken at the last rising edge
      if (write_l) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (strb_l[b]) begin
            mem[addr_l[9:2]][8*b +: 8] = wdata_l[8*b +: 8];
          end
        end
      end else begin
        rvalid <= 1'b1;
        rdata  <= mem[addr_l[9:2]];
      end
    end else if (req) begin
      if (delay < 0) begin
        delay = $unsigned($random(seed)) % 4; // Zero to three cycles
      end
      if (delay == 0) begin
        gnt     <= 1'b1;
        write_l = we;
        addr_l  = addr;
        wdata_l = wdata;
        strb_l  = strb;
        delay   = -1;
      end else begin
        delay = delay - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_core_pkg::*;
(
  input  funct3_t funct3,
  input  logic    alt,
  input  xlen_t   src1,
  input  xlen_t   src2,
  output xlen_t   result
);

  logic [4:0] shamt;

  assign shamt = src2[4:0]; // Only low five bits count

  always_comb begin
    case (funct3)
      3'b000: begin
        if (alt) begin
          result = src1 - src2;
        end else begin
          result = src1 + src2;
        end
      end
      3'b001: result = src1 << shamt;
      3'b010: result = xlen_t'($signed(src1) < $signed(src2));
      3'b011: result = xlen_t'(src1 < src2);
      3'b100: result = src1 ^ src2;
      3'b101: begin
        if (alt) begin
          result = xlen_t'($signed(src1) >>> shamt);
        end else begin
          result = src1 >> shamt;
        end
      end
      3'b110: result = src1 | src2;
      default: result = src1 & src2;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rv_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_control
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      anrst,
  input  logic      nrst,
  output logic      inst_req,
  output xlen_t     inst_addr,
  input  logic      inst_gnt,
  input  logic      inst_rvalid,
  input  ctrl_t     ctrl_in,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data,
  output funct3_t   alu_funct3,
  output logic      alu_alt,
  output xlen_t     alu_src1,
  output xlen_t     alu_src2,
  input  xlen_t     alu_result,
  output logic      mem_start,
  output mem_req_t  mem_out,
  input  logic      mem_done,
  input  xlen_t     load_data,
  output logic      rf_we,
  output reg_addr_t rf_rd,
  output xlen_t     rf_wdata,
  output logic      retire_valid,
  output retire_t   retire
);

  typedef enum logic [2:0] {
    I_FETCH,
    F_WAIT,
    EXEC,
    MEMORY,
    COMMIT
  } state_t;

  state_t state;
  xlen_t  pc;
  xlen_t  pc_plus4;
  xlen_t  pc_next;
  ctrl_t  ctrl_l;
  xlen_t  op1_l;
  xlen_t  op2_l;
  xlen_t  alu_l;
  logic   is_mem;

  assign is_mem   = ctrl_l.mem_rd || ctrl_l.mem_wr;
  assign pc_plus4 = pc + xlen_t'(4);
  assign pc_next  = ctrl_l.jump ? {alu_l[`RV_XLEN-1:1], 1'b0} : pc_plus4;

  assign inst_req  = (state == I_FETCH);
  assign inst_addr = pc;

  always_comb begin
    case (ctrl_l.src1_sel)
      SRC1_PC:   alu_src1 = pc;
      SRC1_ZERO: alu_src1 = '0; // LUI
      default:   alu_src1 = op1_l;
    endcase
  end

  assign alu_src2   = ctrl_l.src2_imm ? ctrl_l.imm : op2_l;
  assign alu_funct3 = ctrl_l.funct3;
  assign alu_alt    = ctrl_l.alt;

  // Data port latches the address from the ALU
  assign mem_start     = (state == EXEC) && is_mem;
  assign mem_out.addr  = alu_result;
  assign mem_out.wdata = op2_l;
  assign mem_out.strb  = '1;
  assign mem_out.we    = ctrl_l.mem_wr;

  always_comb begin
    case (ctrl_l.wb_sel)
      WB_LOAD: rf_wdata = load_data;
      WB_LINK: rf_wdata = pc_plus4;
      default: rf_wdata = alu_l;
    endcase
  end

  assign rf_we = (state == COMMIT) && ctrl_l.wb_en;
  assign rf_rd = ctrl_l.rd;

  assign retire_valid = (state == COMMIT);
  assign retire       = '{pc: pc, rd: ctrl_l.rd, wdata: rf_wdata, we: rf_we};

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      state <= I_FETCH;
      pc    <= `RV_RESET_PC;
    end else if (!nrst) begin
      state <= I_FETCH;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        I_FETCH: if (inst_gnt) state <= F_WAIT;
        F_WAIT:  if (inst_rvalid) state <= EXEC;
        EXEC:    state <= MEMORY;
        MEMORY:  if (!is_mem || mem_done) state <= COMMIT;
        COMMIT: begin
          state <= I_FETCH;
          pc    <= pc_next;
        end
        default: state <= I_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == F_WAIT) && inst_rvalid) begin
      ctrl_l <= ctrl_in;
      op1_l  <= rs1_data; // Regfile indexed by inst_rdata
      op2_l  <= rs2_data;
    end
    if (state == EXEC) begin
      alu_l <= alu_result;
    end
  end

  a_rvalid_in_wait: assert property (
    @(posedge clk) disable iff (!anrst || !nrst) inst_rvalid |-> (state == F_WAIT)
  );

endmodule

`default_nettype wire

/* verilog/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  `include "rv_core_config.svh"

  typedef logic [`RV_XLEN-1:0]   xlen_t;
  typedef logic [4:0]            reg_addr_t;
  typedef logic [`RV_XLEN/8-1:0] strb_t;
  typedef logic [2:0]            funct3_t;

  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_t;

  typedef enum logic [1:0] {
    SRC1_REG,
    SRC1_PC,
    SRC1_ZERO
  } src1_sel_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_t;

  typedef struct packed {
    funct3_t   funct3;
    logic      alt;      // SUB or SRA/SRAI
    logic      src2_imm;
    src1_sel_t src1_sel;
    logic      wb_en;
    wb_sel_t   wb_sel;
    logic      mem_rd;
    logic      mem_wr;
    logic      jump;
    reg_addr_t rd;
    xlen_t     imm;
  } ctrl_t;

  typedef struct packed {
    xlen_t addr;
    xlen_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    xlen_t     pc;
    reg_addr_t rd;
    xlen_t     wdata;
    logic      we;
  } retire_t;

endpackage

`default_nettype wire

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     anrst,
  input  logic     nrst,
  output logic     inst_req,
  output xlen_t    inst_addr,
  input  logic     inst_gnt,
  input  logic     inst_rvalid,
  input  xlen_t    inst_rdata,
  output logic     data_req,
  output mem_req_t data_out,
  input  logic     data_gnt,
  input  logic     data_rvalid,
  input  xlen_t    data_rdata,
  output logic     retire_valid,
  output retire_t  retire
);

  ctrl_t     ctrl;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  funct3_t   alu_funct3;
  logic      alu_alt;
  xlen_t     alu_src1;
  xlen_t     alu_src2;
  xlen_t     alu_result;
  logic      mem_start;
  mem_req_t  mem_req;
  logic      mem_done;
  xlen_t     load_data;
  logic      rf_we;
  reg_addr_t rf_rd;
  xlen_t     rf_wdata;

  rv_control u_rv_control (
    .clk          (clk),
    .anrst        (anrst),
    .nrst         (nrst),
    .inst_req     (inst_req),
    .inst_addr    (inst_addr),
    .inst_gnt     (inst_gnt),
    .inst_rvalid  (inst_rvalid),
    .ctrl_in      (ctrl),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_funct3   (alu_funct3),
    .alu_alt      (alu_alt),
    .alu_src1     (alu_src1),
    .alu_src2     (alu_src2),
    .alu_result   (alu_result),
    .mem_start    (mem_start),
    .mem_out      (mem_req),
    .mem_done     (mem_done),
    .load_data    (load_data),
    .rf_we        (rf_we),
    .rf_rd        (rf_rd),
    .rf_wdata     (rf_wdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  rv_decoder u_rv_decoder (
    .instr (inst_rdata),
    .ctrl  (ctrl)
  );

  rv_alu u_rv_alu (
    .funct3 (alu_funct3),
    .alt    (alu_alt),
    .src1   (alu_src1),
    .src2   (alu_src2),
    .result (alu_result)
  );

  // Read indices taken from the word on the bus
  rv_regfile u_rv_regfile (
    .clk      (clk),
    .anrst    (anrst),
    .nrst     (nrst),
    .rs1      (inst_rdata[19:15]),
    .rs2      (inst_rdata[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .wdata    (rf_wdata)
  );

  rv_data_port u_rv_data_port (
    .clk         (clk),
    .anrst       (anrst),
    .nrst        (nrst),
    .mem_start   (mem_start),
    .mem_in      (mem_req),
    .mem_done    (mem_done),
    .load_data   (load_data),
    .data_req    (data_req),
    .data_out    (data_out),
    .data_gnt    (data_gnt),
    .data_rvalid (data_rvalid),
    .data_rdata  (data_rdata)
  );

endmodule

`default_nettype wire

/* verilog/rv_data_port.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_data_port
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     anrst,
  input  logic     nrst,
  input  logic     mem_start,
  input  mem_req_t mem_in,
  output logic     mem_done,
  output xlen_t    load_data,
  output logic     data_req,
  output mem_req_t data_out,
  input  logic     data_gnt,
  input  logic     data_rvalid,
  input  xlen_t    data_rdata
);

  typedef enum logic [1:0] {
    DP_IDLE,
    DP_REQ,
    DP_WAIT
  } dp_state_t;

  dp_state_t state;
  mem_req_t  req_l;

  assign data_req = (state == DP_REQ);
  assign data_out = req_l;

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      state    <= DP_IDLE;
      mem_done <= 1'b0;
    end else if (!nrst) begin
      state    <= DP_IDLE;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        DP_IDLE: begin
          if (mem_start) begin
            state <= DP_REQ;
          end
        end
        DP_REQ: begin
          if (data_gnt) begin
            if (req_l.we) begin
              state    <= DP_IDLE; // Store done at grant
              mem_done <= 1'b1;
            end else begin
              state <= DP_WAIT;
            end
          end
        end
        DP_WAIT: begin
          if (data_rvalid) begin
            state    <= DP_IDLE;
            mem_done <= 1'b1;
          end
        end
        default: state <= DP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      req_l <= mem_in;
    end
    if ((state == DP_WAIT) && data_rvalid) begin
      load_data <= data_rdata; // Held until next load
    end
  end

  a_rvalid_pending: assert property (
    @(posedge clk) disable iff (!anrst || !nrst) data_rvalid |-> (state == DP_WAIT)
  );

  // Sequencer waits for mem_done before starting another access
  a_start_idle: assert property (
    @(posedge clk) disable iff (!anrst || !nrst) mem_start |-> (state == DP_IDLE)
  );

endmodule

`default_nettype wire

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
  import rv_core_pkg::*;
(
  input  xlen_t instr,
  output ctrl_t ctrl
);

  opcode_t opcode;
  xlen_t   i_imm;
  xlen_t   s_imm;
  xlen_t   u_imm;
  xlen_t   j_imm;

  assign opcode = opcode_t'(instr[6:0]);

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign u_imm = {instr[31:12], 12'h000};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl = '0; // Idle record, ADD, register source
    case (opcode)
      LOAD: begin
        ctrl.src2_imm = 1'b1;
        ctrl.imm      = i_imm;
        ctrl.wb_en    = 1'b1;
        ctrl.wb_sel   = WB_LOAD;
        ctrl.mem_rd   = 1'b1;
        ctrl.rd       = instr[11:7];
      end
      STORE: begin
        ctrl.src2_imm = 1'b1;
        ctrl.imm      = s_imm;
        ctrl.mem_wr   = 1'b1;
      end
      OP_IMM: begin
        ctrl.funct3   = instr[14:12];
        ctrl.alt      = (instr[14:12] == 3'b101) && instr[30]; // SRAI only
        ctrl.src2_imm = 1'b1;
        ctrl.imm      = i_imm;
        ctrl.wb_en    = 1'b1;
        ctrl.rd       = instr[11:7];
      end
      OP: begin
        ctrl.funct3 = instr[14:12];
        ctrl.alt    = instr[30];
        ctrl.wb_en  = 1'b1;
        ctrl.rd     = instr[11:7];
      end
      LUI, AUIPC: begin
        ctrl.src1_sel = (opcode == LUI) ? SRC1_ZERO : SRC1_PC;
        ctrl.src2_imm = 1'b1;
        ctrl.imm      = u_imm;
        ctrl.wb_en    = 1'b1;
        ctrl.rd       = instr[11:7];
      end
      JAL, JALR: begin
        ctrl.src1_sel = (opcode == JAL) ? SRC1_PC : SRC1_REG;
        ctrl.src2_imm = 1'b1;
        ctrl.imm      = (opcode == JAL) ? j_imm : i_imm;
        ctrl.wb_en    = 1'b1;
        ctrl.wb_sel   = WB_LINK;
        ctrl.jump     = 1'b1;
        ctrl.rd       = instr[11:7];
      end
      default: ; // Retires with no effect
    endcase
    if (ctrl.rd == '0) begin
      ctrl.wb_en = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      anrst,
  input  logic      nrst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd,
  input  xlen_t     wdata
);

  xlen_t regs [1:`RV_NREGS-1]; // No storage for x0

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      regs <= '{default: '0};
    end else if (!nrst) begin
      regs <= '{default: '0};
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // Decoder drops x0 destinations before they reach commit
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!anrst) we |-> (rd != '0)
  );

endmodule

`default_nettype wire
